/* common/radio_core_config.svh */
/*
 * Radio core configuration
 * Bus widths, Wishbone address map, settings register map and reset values
 */
`ifndef RADIO_CORE_CONFIG_SVH
`define RADIO_CORE_CONFIG_SVH

// Bus and register widths
`define RC_DW              32
`define RC_AW              16
`define RC_SET_AW          8
`define RC_TIME_W          64

// Address map, compared against byte address bits 15..8
`define RC_SETTINGS_BASE   8'h70
`define RC_SETTINGS_MASK   8'hF0
`define RC_READBACK_BASE   8'h5C
`define RC_READBACK_MASK   8'hFC

// Settings register bases
`define RC_SR_MISC         0
`define RC_SR_TIME64       10

// Misc settings offsets
`define RC_MISC_CLK_OFS      0     // Clock generator control
`define RC_MISC_LED_SW_OFS   3
`define RC_MISC_PHY_OFS      4
`define RC_MISC_LED_SRC_OFS  6     // 1 = hardware, 0 = software

// Time settings offsets
`define RC_TIME_HI_OFS     0
`define RC_TIME_LO_OFS     1
`define RC_TIME_MODE_OFS   2       // Bit 0 set loads now, clear arms for PPS

// Compatibility number, bump when the register map changes
`define RC_COMPAT_MAJOR    16'd7
`define RC_COMPAT_MINOR    16'd1

// Reset values
`define RC_LED_SRC_RESET   8'h1E

`endif

/* common/radio_core_pkg.sv */
/*
 * Radio core shared types
 * Bus words, settings address, time value and the decode and timer enums
 */
`default_nettype none

package radio_core_pkg;

`include "radio_core_config.svh"

   //////////////////////////////////////////////////////////////
   // Bus and settings types

   typedef logic [`RC_AW-1:0]     wb_adr_t;     // Byte address
   typedef logic [`RC_DW-1:0]     wb_dat_t;
   typedef logic [`RC_SET_AW-1:0] set_addr_t;   // Byte address bits 9..2

   //////////////////////////////////////////////////////////////
   // Time types

   typedef logic [`RC_TIME_W-1:0] vita_time_t;  // Tick count

   //////////////////////////////////////////////////////////////
   // Enums

   // Slave selected by the intercon decode
   typedef enum logic [1:0] {
      SLV_NONE,
      SLV_READBACK,
      SLV_SETTINGS
   } wb_slave_e;

   // Timer load state
   typedef enum logic {
      TIME_FREE,
      TIME_ARMED     // Waiting for the next PPS edge
   } time_load_e;

endpackage

`default_nettype wire

/* wishbone_bus/wb_intercon.sv */
/*
 * Wishbone single master intercon
 * Decodes the readback and settings regions, errors on unmapped addresses
 */
`timescale 1ns/100ps
`default_nettype none

`include "radio_core_config.svh"

module wb_intercon (
   input  logic                    dsp_clk,
   input  logic                    por_rst,
   input  logic                    m_cyc_i,
   input  logic                    m_stb_i,
   input  logic                    m_we_i,
   input  radio_core_pkg::wb_adr_t m_adr_i,
   input  radio_core_pkg::wb_dat_t m_dat_i,
   output radio_core_pkg::wb_dat_t m_dat_o,
   output logic                    m_ack_o,
   output logic                    m_err_o,
   output logic                    s_we_o,
   output radio_core_pkg::wb_adr_t s_adr_o,
   output radio_core_pkg::wb_dat_t s_dat_o,
   output logic                    rb_stb_o,
   input  radio_core_pkg::wb_dat_t rb_dat_i,
   input  logic                    rb_ack_i,
   output logic                    set_stb_o,
   input  logic                    set_ack_i
);

   radio_core_pkg::wb_slave_e slave;
   logic [7:0]                page;       // Byte address bits 15..8
   logic                      req;
   logic                      err_q;

   assign page = m_adr_i[`RC_AW-1 -: 8];
   assign req  = m_cyc_i & m_stb_i;

   always_comb begin
      if ((page & `RC_SETTINGS_MASK) == `RC_SETTINGS_BASE)
         slave = radio_core_pkg::SLV_SETTINGS;
      else if ((page & `RC_READBACK_MASK) == `RC_READBACK_BASE)
         slave = radio_core_pkg::SLV_READBACK;
      else
         slave = radio_core_pkg::SLV_NONE;
   end

   // Request fields go to both slaves, only the strobe is gated
   assign s_we_o    = m_we_i;
   assign s_adr_o   = m_adr_i;
   assign s_dat_o   = m_dat_i;
   assign rb_stb_o  = req & (slave == radio_core_pkg::SLV_READBACK);
   assign set_stb_o = req & (slave == radio_core_pkg::SLV_SETTINGS);

   ////////////////////////////////////////////////////////////
   // Return path

   // Unmapped access, one pulse per request
   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         err_q <= 1'b0;
      else
         err_q <= req & (slave == radio_core_pkg::SLV_NONE) & ~err_q;
   end

   assign m_err_o = err_q;
   assign m_ack_o = rb_ack_i | set_ack_i;
   assign m_dat_o = (slave == radio_core_pkg::SLV_READBACK) ? rb_dat_i : '0;  // Settings read 0

endmodule

`default_nettype wire

/* wishbone_bus/settings_bus.sv */
/*
 * Settings bus
 * Turns Wishbone writes into a one cycle strobe with word address and data
 */
`timescale 1ns/100ps
`default_nettype none

module settings_bus (
   input  logic                      dsp_clk,
   input  logic                      por_rst,
   input  logic                      wb_stb_i,
   input  logic                      wb_we_i,
   input  radio_core_pkg::wb_adr_t   wb_adr_i,
   input  radio_core_pkg::wb_dat_t   wb_dat_i,
   output logic                      wb_ack_o,
   output logic                      set_stb_o,
   output radio_core_pkg::set_addr_t set_addr_o,
   output radio_core_pkg::wb_dat_t   set_data_o
);

   logic new_req;

   // Hold off while acking so a held strobe is taken once
   assign new_req = wb_stb_i & ~wb_ack_o;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         wb_ack_o  <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         wb_ack_o  <= new_req;
         set_stb_o <= new_req & wb_we_i;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (new_req & wb_we_i) begin
         set_addr_o <= wb_adr_i[9:2];     // Word address
         set_data_o <= wb_dat_i;
      end
   end

endmodule

`default_nettype wire

/* wishbone_bus/readback_mux.sv */
/*
 * Readback mux
 * Returns time, PPS time and the compatibility number by word address
 */
`timescale 1ns/100ps
`default_nettype none

`include "radio_core_config.svh"

module readback_mux (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  logic                       wb_stb_i,
   input  radio_core_pkg::wb_adr_t    wb_adr_i,
   input  radio_core_pkg::vita_time_t vita_time_i,
   input  radio_core_pkg::vita_time_t vita_time_pps_i,
   output radio_core_pkg::wb_dat_t    wb_dat_o,
   output logic                       wb_ack_o
);

   radio_core_pkg::wb_dat_t word;

   always_comb begin
      case (wb_adr_i[5:2])
         4'd10:   word = vita_time_i[63:32];
         4'd11:   word = vita_time_i[31:0];
         4'd12:   word = {`RC_COMPAT_MAJOR, `RC_COMPAT_MINOR};
         4'd14:   word = vita_time_pps_i[63:32];
         4'd15:   word = vita_time_pps_i[31:0];
         default: word = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         wb_ack_o <= 1'b0;
      else
         wb_ack_o <= wb_stb_i & ~wb_ack_o;
   end

   // Sampled with the strobe, valid alongside ack
   always_ff @(posedge dsp_clk) begin
      if (wb_stb_i)
         wb_dat_o <= word;
   end

endmodule

`default_nettype wire

/* design/misc_settings.sv */
/*
 * Misc setting registers
 * Clock generator control, PHY reset and the LED hardware or software mix
 */
`timescale 1ns/100ps
`default_nettype none

`include "radio_core_config.svh"

module misc_settings (
   input  logic                      dsp_clk,
   input  logic                      por_rst,
   input  logic                      set_stb_i,
   input  radio_core_pkg::set_addr_t set_addr_i,
   input  radio_core_pkg::wb_dat_t   set_data_i,
   input  logic                      clk_status_i,
   input  logic                      time_armed_i,
   output logic                      clock_ready_o,
   output logic [1:0]                clk_en_o,
   output logic [1:0]                clk_sel_o,
   output logic                      phy_reset_n_o,
   output logic [7:0]                leds_o
);

   localparam radio_core_pkg::set_addr_t ADDR_CLK =
      radio_core_pkg::set_addr_t'(`RC_SR_MISC + `RC_MISC_CLK_OFS);
   localparam radio_core_pkg::set_addr_t ADDR_LED_SW =
      radio_core_pkg::set_addr_t'(`RC_SR_MISC + `RC_MISC_LED_SW_OFS);
   localparam radio_core_pkg::set_addr_t ADDR_PHY =
      radio_core_pkg::set_addr_t'(`RC_SR_MISC + `RC_MISC_PHY_OFS);
   localparam radio_core_pkg::set_addr_t ADDR_LED_SRC =
      radio_core_pkg::set_addr_t'(`RC_SR_MISC + `RC_MISC_LED_SRC_OFS);

   logic [4:0] clock_outs;    // {ready, en[1:0], sel[1:0]}
   logic [7:0] led_sw, led_src;
   logic       phy_reset;
   logic [7:0] led_hw;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clock_outs <= '0;
         led_sw     <= '0;
         phy_reset  <= 1'b0;
         led_src    <= `RC_LED_SRC_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            ADDR_CLK:     clock_outs <= set_data_i[4:0];
            ADDR_LED_SW:  led_sw     <= set_data_i[7:0];
            ADDR_PHY:     phy_reset  <= set_data_i[0];
            ADDR_LED_SRC: led_src    <= set_data_i[7:0];
            default: ;                                   // Other consumers
         endcase
      end
   end

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_outs;
   assign phy_reset_n_o = ~phy_reset;

   // Hardware status sources, upper LEDs have none
   assign led_hw = {6'b0, time_armed_i, clk_status_i};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

/* vita_time/vita_timer.sv */
/*
 * VITA time counter
 * 64-bit tick counter with immediate or PPS armed load and PPS time latch
 */
`timescale 1ns/100ps
`default_nettype none

`include "radio_core_config.svh"

module vita_timer (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  logic                       set_stb_i,
   input  radio_core_pkg::set_addr_t  set_addr_i,
   input  radio_core_pkg::wb_dat_t    set_data_i,
   input  logic                       pps_i,
   output radio_core_pkg::vita_time_t vita_time_o,
   output radio_core_pkg::vita_time_t vita_time_pps_o,
   output logic                       time_armed_o,
   output logic                       pps_int_o
);

   localparam radio_core_pkg::set_addr_t ADDR_HI =
      radio_core_pkg::set_addr_t'(`RC_SR_TIME64 + `RC_TIME_HI_OFS);
   localparam radio_core_pkg::set_addr_t ADDR_LO =
      radio_core_pkg::set_addr_t'(`RC_SR_TIME64 + `RC_TIME_LO_OFS);
   localparam radio_core_pkg::set_addr_t ADDR_MODE =
      radio_core_pkg::set_addr_t'(`RC_SR_TIME64 + `RC_TIME_MODE_OFS);

   radio_core_pkg::wb_dat_t    staged_hi, staged_lo;
   radio_core_pkg::vita_time_t time_next;
   radio_core_pkg::time_load_e state;
   logic [2:0]                 pps_sr;     // Two sync flops, then edge history
   logic                       pps_edge;
   logic                       mode_wr;

   ////////////////////////////////////////////////////////////
   // Staged time and PPS edge

   always_ff @(posedge dsp_clk) begin
      if (set_stb_i && set_addr_i == ADDR_HI)
         staged_hi <= set_data_i;
      if (set_stb_i && set_addr_i == ADDR_LO)
         staged_lo <= set_data_i;
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         pps_sr <= '0;
      else
         pps_sr <= {pps_sr[1:0], pps_i};
   end

   assign pps_edge = pps_sr[1] & ~pps_sr[2];
   assign mode_wr  = set_stb_i && (set_addr_i == ADDR_MODE);

   ////////////////////////////////////////////////////////////
   // Counter

   always_comb begin
      if (mode_wr && set_data_i[0])
         time_next = {staged_hi, staged_lo};            // Load now
      else if (pps_edge && state == radio_core_pkg::TIME_ARMED)
         time_next = {staged_hi, staged_lo};
      else
         time_next = vita_time_o + 1'b1;
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         state           <= radio_core_pkg::TIME_FREE;
         pps_int_o       <= 1'b0;
      end else begin
         vita_time_o <= time_next;
         pps_int_o   <= pps_edge;
         if (pps_edge)
            vita_time_pps_o <= time_next;               // Includes an armed load
         if (mode_wr)
            state <= set_data_i[0] ? radio_core_pkg::TIME_FREE : radio_core_pkg::TIME_ARMED;
         else if (pps_edge)
            state <= radio_core_pkg::TIME_FREE;
      end
   end

   assign time_armed_o = (state == radio_core_pkg::TIME_ARMED);

endmodule

`default_nettype wire

/* design/radio_core_top.sv */
/*
 * Radio core top level
 * Wishbone fabric, settings bus, misc registers, readback and VITA time
 */
`timescale 1ns/100ps
`default_nettype none

module radio_core_top (
   input  logic                     dsp_clk,
   input  logic                     por_rst,
   // Wishbone classic from the external master
   input  logic                     wb_cyc_i,
   input  logic                     wb_stb_i,
   input  logic                     wb_we_i,
   input  radio_core_pkg::wb_adr_t  wb_adr_i,
   input  radio_core_pkg::wb_dat_t  wb_dat_i,
   output radio_core_pkg::wb_dat_t  wb_dat_o,
   output logic                     wb_ack_o,
   output logic                     wb_err_o,
   // Board signals
   input  logic                     pps_i,
   input  logic                     clk_status_i,
   output logic [7:0]               leds_o,
   output logic                     clock_ready_o,
   output logic [1:0]               clk_en_o,
   output logic [1:0]               clk_sel_o,
   output logic                     phy_reset_n_o,
   output logic                     pps_int_o
);

   radio_core_pkg::wb_adr_t    s_adr;
   radio_core_pkg::wb_dat_t    s_dat;
   radio_core_pkg::wb_dat_t    rb_dat;
   logic                       s_we;
   logic                       rb_stb, rb_ack;
   logic                       set_wb_stb, set_ack;

   logic                       set_stb;
   radio_core_pkg::set_addr_t  set_addr;
   radio_core_pkg::wb_dat_t    set_data;

   radio_core_pkg::vita_time_t vita_time, vita_time_pps;
   logic                       time_armed;

   ////////////////////////////////////////////////////////////
   // Bus fabric

   wb_intercon intercon0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .m_cyc_i(wb_cyc_i), .m_stb_i(wb_stb_i), .m_we_i(wb_we_i),
      .m_adr_i(wb_adr_i), .m_dat_i(wb_dat_i),
      .m_dat_o(wb_dat_o), .m_ack_o(wb_ack_o), .m_err_o(wb_err_o),
      .s_we_o(s_we), .s_adr_o(s_adr), .s_dat_o(s_dat),
      .rb_stb_o(rb_stb), .rb_dat_i(rb_dat), .rb_ack_i(rb_ack),
      .set_stb_o(set_wb_stb), .set_ack_i(set_ack));

   settings_bus settings0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .wb_stb_i(set_wb_stb), .wb_we_i(s_we), .wb_adr_i(s_adr), .wb_dat_i(s_dat),
      .wb_ack_o(set_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   readback_mux readback0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .wb_stb_i(rb_stb), .wb_adr_i(s_adr),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .wb_dat_o(rb_dat), .wb_ack_o(rb_ack));

   ////////////////////////////////////////////////////////////
   // Settings consumers

   misc_settings misc0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .clk_status_i(clk_status_i), .time_armed_i(time_armed),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o));

   vita_timer timer0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps),
      .time_armed_o(time_armed), .pps_int_o(pps_int_o));

endmodule

`default_nettype wire

/* verification/radio_core_tb.sv */
/*
 * Radio core testbench
 * Plays the Wishbone master and checks settings, LEDs, decode errors and VITA time
 */
`timescale 1ns/100ps
`default_nettype none

`include "radio_core_config.svh"

module radio_core_tb;

   localparam int MAX_CYCLES = 5000;     // Whole run needs a few hundred cycles
   localparam int ACK_LIMIT  = 16;
   localparam int PPS_LIMIT  = 5;
   localparam int SA_CLK     = `RC_SR_MISC + `RC_MISC_CLK_OFS;
   localparam int SA_LED_SW  = `RC_SR_MISC + `RC_MISC_LED_SW_OFS;
   localparam int SA_PHY     = `RC_SR_MISC + `RC_MISC_PHY_OFS;
   localparam int SA_LED_SRC = `RC_SR_MISC + `RC_MISC_LED_SRC_OFS;
   localparam int SA_T_HI    = `RC_SR_TIME64 + `RC_TIME_HI_OFS;
   localparam int SA_T_LO    = `RC_SR_TIME64 + `RC_TIME_LO_OFS;
   localparam int SA_T_MODE  = `RC_SR_TIME64 + `RC_TIME_MODE_OFS;
   localparam int SA_UNUSED  = 40;       // Nothing decodes this one

   logic                    dsp_clk = 1'b0;
   logic                    por_rst;
   logic                    wb_cyc, wb_stb, wb_we;
   radio_core_pkg::wb_adr_t wb_adr;
   radio_core_pkg::wb_dat_t wb_dat_w, wb_dat_r;
   logic                    wb_ack, wb_err;
   logic                    pps, clk_status;
   logic [7:0]              leds;
   logic                    clock_ready, phy_reset_n, pps_int;
   logic [1:0]              clk_en, clk_sel;
   int unsigned             cycle_count = 0;

   radio_core_top dut0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
      .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
      .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack), .wb_err_o(wb_err),
      .pps_i(pps), .clk_status_i(clk_status), .leds_o(leds),
      .clock_ready_o(clock_ready), .clk_en_o(clk_en), .clk_sel_o(clk_sel),
      .phy_reset_n_o(phy_reset_n), .pps_int_o(pps_int));

   always #4 dsp_clk = ~dsp_clk;        // 8 ns period

   always @(posedge dsp_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
         $display("Errors found");
         $fatal(1, "Run stopped by the cycle limit");
      end
   end

   task automatic stop_run(input string what);
      $display("%s", what);
      $display("Errors found");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic expect_equal(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
      assert (act === exp)
      else stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic expect_in_range(input string name, input logic [63:0] lo,
                                  input logic [63:0] hi, input logic [63:0] act);
      assert (act >= lo && act < hi)
      else stop_run($sformatf("Fail %s: expected %h to %h, actual %h", name, lo, hi, act));
   endtask

   ////////////////////////////////////////////////////////////
   // Bus protocol checks

   assert property (@(posedge dsp_clk) disable iff (por_rst)
      (wb_cyc && wb_stb && !wb_ack && !wb_err) |=> (wb_ack ^ wb_err))
      else stop_run("Bus access did not end in one ack or err in the next cycle");

   assert property (@(posedge dsp_clk) disable iff (por_rst)
      (wb_ack || wb_err) |=> !(wb_ack || wb_err))
      else stop_run("Bus response lasted longer than one cycle");

   ////////////////////////////////////////////////////////////
   // Bus master

   task automatic bus_cycle(input logic we, input radio_core_pkg::wb_adr_t adr,
                            input radio_core_pkg::wb_dat_t wdat,
                            output radio_core_pkg::wb_dat_t rdat, output logic err);
      int waited = 0;
      @(negedge dsp_clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      @(negedge dsp_clk);
      while (!wb_ack && !wb_err) begin
         waited++;
         if (waited >= ACK_LIMIT)
            stop_run($sformatf("No ack or err came back for the access to %h", adr));
         @(negedge dsp_clk);
      end
      rdat   = wb_dat_r;
      err    = wb_err;
      wb_cyc = 1'b0;                     // Idle at least one cycle
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_setting(input int sa, input radio_core_pkg::wb_dat_t data);
      radio_core_pkg::wb_dat_t rdat;
      logic                    err;
      bus_cycle(1'b1, 16'({`RC_SETTINGS_BASE, 8'h00}) | 16'(sa << 2), data, rdat, err);
      expect_equal("settings write err", 0, err);
   endtask

   task automatic read_word(input int word, output radio_core_pkg::wb_dat_t data);
      logic err;
      bus_cycle(1'b0, 16'({`RC_READBACK_BASE, 8'h00}) | 16'(word << 2), '0, data, err);
      expect_equal("readback err", 0, err);
   endtask

   // High word first so the low word read gives the sample cycle
   task automatic read_time(input int hi_word, input int lo_word,
                            output radio_core_pkg::vita_time_t t, output int unsigned at);
      radio_core_pkg::wb_dat_t hi;
      radio_core_pkg::wb_dat_t lo;
      read_word(hi_word, hi);
      read_word(lo_word, lo);
      at = cycle_count;
      t  = {hi, lo};
   endtask

   function automatic logic [7:0] led_mix(input logic [7:0] src, input logic [7:0] sw,
                                          input logic [7:0] hw);
      logic [7:0] mix;
      for (int i = 0; i < 8; i++)
         mix[i] = src[i] ? hw[i] : sw[i];
      return mix;
   endfunction

   function automatic logic [14:0] output_state();
      return {leds, clock_ready, clk_en, clk_sel, phy_reset_n, pps_int};
   endfunction

   ////////////////////////////////////////////////////////////
   // Stimulus

   initial begin
      radio_core_pkg::wb_dat_t    data, clk_val, phy_val, sw_val, src_val;
      radio_core_pkg::vita_time_t t_load, t_first, t_second;
      logic                       err;
      logic [14:0]                outs_expected;
      int unsigned                load_cycle, sample_cycle;
      int                         waited;

      void'($urandom(32'hd5930307));
      {wb_cyc, wb_stb, wb_we, pps, clk_status} = '0;
      wb_adr   = '0;
      wb_dat_w = '0;
      por_rst  = 1'b1;

      // Reset state checked in the last reset cycle
      repeat (8) @(negedge dsp_clk);
      expect_equal("reset outputs", 15'b0000_0000_0_00_00_1_0, output_state());
      expect_equal("reset ack err", 0, {wb_ack, wb_err});
      expect_equal("reset time", 0, dut0.timer0.vita_time_o);
      expect_equal("reset armed", 0, dut0.timer0.time_armed_o);
      por_rst = 1'b0;
      read_word(12, data);
      expect_equal("compat word", 32'h0007_0001, data);

      // Clock control and PHY reset
      repeat (4) begin
         clk_val = $urandom;
         phy_val = $urandom;
         write_setting(SA_CLK, clk_val);
         @(negedge dsp_clk);
         expect_equal("clock ready", clk_val[4], clock_ready);
         expect_equal("clock enables", clk_val[3:2], clk_en);
         expect_equal("clock selects", clk_val[1:0], clk_sel);
         write_setting(SA_PHY, phy_val);
         @(negedge dsp_clk);
         expect_equal("phy reset", !phy_val[0], phy_reset_n);
      end

      // LED source mix with the timer not armed
      repeat (6) begin
         sw_val     = $urandom;
         src_val    = $urandom;
         clk_status = 1'($urandom);
         write_setting(SA_LED_SW, sw_val);
         write_setting(SA_LED_SRC, src_val);
         @(negedge dsp_clk);
         expect_equal("leds", led_mix(src_val[7:0], sw_val[7:0], {7'b0, clk_status}), leds);
      end

      // Unmapped accesses and an unused setting
      bus_cycle(1'b0, 16'h1000, '0, data, err);
      expect_equal("unmapped read err", 1, err);
      bus_cycle(1'b1, 16'hA004, $urandom, data, err);
      expect_equal("unmapped write err", 1, err);
      write_setting(SA_UNUSED, $urandom);
      @(negedge dsp_clk);
      outs_expected = {led_mix(src_val[7:0], sw_val[7:0], {7'b0, clk_status}), clk_val[4],
                       clk_val[3:2], clk_val[1:0], !phy_val[0], 1'b0};
      expect_equal("unused setting", outs_expected, output_state());

      // Immediate load with a small low word so no carry
      t_load = {32'($urandom), 32'($urandom) & 32'h0000_0FFF};
      write_setting(SA_T_HI, t_load[63:32]);
      write_setting(SA_T_LO, t_load[31:0]);
      write_setting(SA_T_MODE, 32'h1);
      load_cycle = cycle_count;
      read_time(10, 11, t_first, sample_cycle);
      expect_in_range("time after load", t_load, t_load + (sample_cycle - load_cycle), t_first);
      read_time(10, 11, t_second, sample_cycle);
      expect_in_range("time advances", t_first + 1, t_load + (sample_cycle - load_cycle),
                      t_second);

      // Armed load on PPS
      write_setting(SA_LED_SRC, `RC_LED_SRC_RESET);
      t_load = {32'($urandom), 32'($urandom)};
      write_setting(SA_T_HI, t_load[63:32]);
      write_setting(SA_T_LO, t_load[31:0]);
      write_setting(SA_T_MODE, 32'h0);
      @(negedge dsp_clk);
      expect_equal("time armed", 1, dut0.timer0.time_armed_o);
      expect_equal("armed led", 1, leds[1]);
      pps    = 1'b1;
      waited = 0;
      @(negedge dsp_clk);
      while (!pps_int) begin
         waited++;
         if (waited >= PPS_LIMIT)
            stop_run("pps_int_o did not pulse within 5 cycles of pps_i going high");
         @(negedge dsp_clk);
      end
      expect_equal("armed after pps", 0, dut0.timer0.time_armed_o);
      @(negedge dsp_clk);
      expect_equal("pps pulse width", 0, pps_int);
      expect_equal("led after pps", 0, leds[1]);
      pps = 1'b0;
      read_time(14, 15, t_first, sample_cycle);
      expect_equal("pps time", t_load, t_first);

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

/* radio_core_top.f */
+incdir+common
common/radio_core_pkg.sv
wishbone_bus/wb_intercon.sv
wishbone_bus/settings_bus.sv
wishbone_bus/readback_mux.sv
design/misc_settings.sv
vita_time/vita_timer.sv
design/radio_core_top.sv
verification/radio_core_tb.sv
